// File: logic/ice_pkg.sv
package ice_pkg;
	//Bus widths
	localparam int BYTE_W = 8;
	localparam int NUM_SLAVES = 2;
	localparam int NUM_PWR_SW = 3;

	//Frame addresses of the slaves
	//Index 0 is the settings block and index 1 the echo port
	localparam logic [BYTE_W-1:0] ADDR_SETTINGS = 8'h01;
	localparam logic [BYTE_W-1:0] ADDR_ECHO = 8'h02;

	//Reply status bytes
	localparam logic [BYTE_W-1:0] STATUS_ACK = 8'h00;
	localparam logic [BYTE_W-1:0] STATUS_NAK = 8'h01;

	//Settings opcodes
	//Read is opcode and index, write adds a value
	localparam logic [BYTE_W-1:0] OP_READ = 8'h00;
	localparam logic [BYTE_W-1:0] OP_WRITE = 8'h01;

	//Settings register indices
	localparam logic [BYTE_W-1:0] REG_GPIO_LEVEL = 8'd0;
	localparam logic [BYTE_W-1:0] REG_POWER_SW = 8'd1;
	localparam logic [BYTE_W-1:0] REG_SCRATCH = 8'd2;
	//Read only, frames seen on the master bus
	localparam logic [BYTE_W-1:0] REG_FRAME_COUNT = 8'd3;

	//Echo buffer geometry
	localparam int ECHO_DEPTH = 8;
	localparam int ECHO_PTR_W = $clog2(ECHO_DEPTH);
	localparam int ECHO_CNT_W = ECHO_PTR_W + 1;
	//Fill level at which the next byte overflows
	localparam logic [ECHO_CNT_W-1:0] ECHO_FULL = ECHO_CNT_W'(ECHO_DEPTH);
endpackage

// File: logic/frame_decoder.sv
module frame_decoder (
	input clk,
	input rst,

	//Character stream from the host
	input [ice_pkg::BYTE_W-1:0] rx_char,
	input rx_char_valid,

	//Master bus
	output logic [ice_pkg::BYTE_W-1:0] ma_addr,
	output logic [ice_pkg::BYTE_W-1:0] ma_data,
	output logic ma_data_valid,
	output logic ma_frame_valid,
	output logic ma_frame_end,
	output logic generate_nak
);

	typedef enum logic [1:0] {
		ST_ADDR,
		ST_LEN,
		ST_PAYLOAD
	} state_t;

	state_t state;
	logic [ice_pkg::BYTE_W-1:0] remaining;
	logic addr_known;

	//Address belongs to one of the slaves
	assign addr_known = (ma_addr == ice_pkg::ADDR_SETTINGS) ||
		(ma_addr == ice_pkg::ADDR_ECHO);

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_ADDR;
			remaining <= '0;
			ma_data_valid <= 1'b0;
			ma_frame_valid <= 1'b0;
			ma_frame_end <= 1'b0;
			generate_nak <= 1'b0;
		end else begin
			//Strobes last a single cycle
			ma_data_valid <= 1'b0;
			ma_frame_end <= 1'b0;
			generate_nak <= 1'b0;
			//Frame valid falls right after the end pulse
			if (ma_frame_end)
				ma_frame_valid <= 1'b0;

			if (rx_char_valid) begin
				case (state)
					ST_ADDR: begin
						ma_addr <= rx_char;
						state <= ST_LEN;
					end
					ST_LEN: begin
						ma_frame_valid <= 1'b1;
						remaining <= rx_char;
						//Empty frame opens and closes in one cycle
						if (rx_char == '0) begin
							ma_frame_end <= 1'b1;
							generate_nak <= !addr_known;
							state <= ST_ADDR;
						end else begin
							state <= ST_PAYLOAD;
						end
					end
					default: begin
						ma_data <= rx_char;
						ma_data_valid <= 1'b1;
						remaining <= remaining - 1'b1;
						//Last payload byte closes the frame
						if (remaining == 8'd1) begin
							ma_frame_end <= 1'b1;
							generate_nak <= !addr_known;
							state <= ST_ADDR;
						end
					end
				endcase
			end
		end
	end

endmodule

// File: logic/settings_regs.sv
module settings_regs (
	input clk,
	input rst,

	//Master bus
	input [ice_pkg::BYTE_W-1:0] ma_addr,
	input [ice_pkg::BYTE_W-1:0] ma_data,
	input ma_data_valid,
	input ma_frame_valid,
	input ma_frame_end,

	//Return bus
	output logic sl_arb_request,
	input sl_arb_grant,
	input sl_latch,
	output logic [ice_pkg::BYTE_W-1:0] sl_len,
	output logic [ice_pkg::BYTE_W-1:0] sl_data,

	//Board settings
	output logic [ice_pkg::BYTE_W-1:0] gpio_level,
	output logic [ice_pkg::NUM_PWR_SW-1:0] power_sw
);

	logic [ice_pkg::BYTE_W-1:0] pay [3];
	logic [2:0] cnt;
	logic [2:0] len_now;
	logic [ice_pkg::BYTE_W-1:0] op_b, idx_b, val_b;
	logic [ice_pkg::BYTE_W-1:0] scratch;
	logic [ice_pkg::BYTE_W-1:0] frame_count;
	logic take;
	logic rsp_ok, wr_en;
	logic [ice_pkg::BYTE_W-1:0] rsp_val;
	logic [ice_pkg::BYTE_W-1:0] reply_status, reply_value;
	logic step;

	//Our frame, and no reply still pending
	assign take = ma_frame_valid && (ma_addr == ice_pkg::ADDR_SETTINGS) && !sl_arb_request;

	//Payload view including the byte on the bus this cycle
	//Count saturates at 4 since any longer frame is bad anyway
	always_comb begin
		op_b = pay[0];
		idx_b = pay[1];
		val_b = pay[2];
		len_now = cnt;
		if (ma_data_valid && cnt < 3'd4) begin
			len_now = cnt + 3'd1;
			case (cnt)
				3'd0: op_b = ma_data;
				3'd1: idx_b = ma_data;
				3'd2: val_b = ma_data;
				default: ;
			endcase
		end
	end

	//Command decode
	always_comb begin
		rsp_ok = 1'b0;
		wr_en = 1'b0;
		rsp_val = '0;
		if (op_b == ice_pkg::OP_READ && len_now == 3'd2) begin
			rsp_ok = 1'b1;
			case (idx_b)
				ice_pkg::REG_GPIO_LEVEL: rsp_val = gpio_level;
				ice_pkg::REG_POWER_SW:
					rsp_val = {{(ice_pkg::BYTE_W-ice_pkg::NUM_PWR_SW){1'b0}}, power_sw};
				ice_pkg::REG_SCRATCH: rsp_val = scratch;
				//Count includes the frame being read
				ice_pkg::REG_FRAME_COUNT: rsp_val = frame_count + 1'b1;
				default: rsp_ok = 1'b0;
			endcase
		end else if (op_b == ice_pkg::OP_WRITE && len_now == 3'd3 &&
				idx_b < ice_pkg::REG_FRAME_COUNT) begin
			rsp_ok = 1'b1;
			wr_en = 1'b1;
			rsp_val = val_b;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt <= '0;
			step <= 1'b0;
			sl_arb_request <= 1'b0;
			gpio_level <= '0;
			power_sw <= '0;
			scratch <= '0;
			frame_count <= '0;
		end else begin
			//Every frame on the bus is counted
			if (ma_frame_end) begin
				frame_count <= frame_count + 1'b1;
				cnt <= '0;
			end else if (take && ma_data_valid && cnt < 3'd4) begin
				cnt <= cnt + 3'd1;
			end

			if (take && ma_frame_end) begin
				sl_arb_request <= 1'b1;
				step <= 1'b0;
				if (wr_en) begin
					case (idx_b)
						ice_pkg::REG_GPIO_LEVEL: gpio_level <= val_b;
						ice_pkg::REG_POWER_SW: power_sw <= val_b[ice_pkg::NUM_PWR_SW-1:0];
						default: scratch <= val_b;
					endcase
				end
			end else if (sl_arb_grant && sl_latch) begin
				//Status goes first, then value ends the reply
				if (step)
					sl_arb_request <= 1'b0;
				else
					step <= 1'b1;
			end
		end
	end

	//Captured bytes and reply contents
	always_ff @(posedge clk) begin
		if (take && ma_data_valid && cnt < 3'd3)
			pay[cnt[1:0]] <= ma_data;
		if (take && ma_frame_end) begin
			reply_status <= rsp_ok ? ice_pkg::STATUS_ACK : ice_pkg::STATUS_NAK;
			reply_value <= rsp_val;
		end
	end

	assign sl_len = 8'd2;
	assign sl_data = step ? reply_value : reply_status;

endmodule

// File: logic/echo_port.sv
module echo_port (
	input clk,
	input rst,

	//Master bus
	input [ice_pkg::BYTE_W-1:0] ma_addr,
	input [ice_pkg::BYTE_W-1:0] ma_data,
	input ma_data_valid,
	input ma_frame_valid,
	input ma_frame_end,

	//Return bus
	output logic sl_arb_request,
	input sl_arb_grant,
	input sl_latch,
	output logic [ice_pkg::BYTE_W-1:0] sl_len,
	output logic [ice_pkg::BYTE_W-1:0] sl_data
);

	logic [ice_pkg::BYTE_W-1:0] mem [ice_pkg::ECHO_DEPTH];
	logic [ice_pkg::ECHO_CNT_W-1:0] wr_cnt, rd_ptr, reply_len, count_now;
	logic overflow, overflow_now, nak;
	logic take, full;

	assign take = ma_frame_valid && (ma_addr == ice_pkg::ADDR_ECHO) && !sl_arb_request;
	assign full = (wr_cnt == ice_pkg::ECHO_FULL);

	//Frame totals including the byte arriving with the end pulse
	assign count_now = (ma_data_valid && !full) ? wr_cnt + 1'b1 : wr_cnt;
	assign overflow_now = overflow || (ma_data_valid && full);

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_cnt <= '0;
			rd_ptr <= '0;
			overflow <= 1'b0;
			nak <= 1'b0;
			sl_arb_request <= 1'b0;
		end else if (take && ma_frame_end) begin
			sl_arb_request <= 1'b1;
			rd_ptr <= '0;
			nak <= overflow_now;
			reply_len <= count_now;
			//Buffer is free for the next frame once the reply is gone
			wr_cnt <= '0;
			overflow <= 1'b0;
		end else begin
			//Sticky until frame end
			if (take && ma_data_valid) begin
				if (full)
					overflow <= 1'b1;
				else
					wr_cnt <= wr_cnt + 1'b1;
			end
			//One latch per byte, or a single one for an empty reply
			if (sl_arb_grant && sl_latch) begin
				if (nak || rd_ptr + 1'b1 >= reply_len)
					sl_arb_request <= 1'b0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take && ma_data_valid && !full)
			mem[wr_cnt[ice_pkg::ECHO_PTR_W-1:0]] <= ma_data;
	end

	//Overflow replies a lone NAK status
	assign sl_len = nak ? 8'd1 :
		{{(ice_pkg::BYTE_W-ice_pkg::ECHO_CNT_W){1'b0}}, reply_len};
	assign sl_data = nak ? ice_pkg::STATUS_NAK : mem[rd_ptr[ice_pkg::ECHO_PTR_W-1:0]];

endmodule

// File: logic/reply_arbiter.sv
module reply_arbiter (
	input clk,
	input rst,

	//Return bus
	input [ice_pkg::NUM_SLAVES-1:0] sl_arb_request,
	output logic [ice_pkg::NUM_SLAVES-1:0] sl_arb_grant,
	output logic sl_latch,
	input [ice_pkg::BYTE_W-1:0] sl_len_0,
	input [ice_pkg::BYTE_W-1:0] sl_data_0,
	input [ice_pkg::BYTE_W-1:0] sl_len_1,
	input [ice_pkg::BYTE_W-1:0] sl_data_1,

	//Immediate NAK from the decoder
	input generate_nak,
	input [ice_pkg::BYTE_W-1:0] ma_addr,

	//Character output to the host
	output logic [ice_pkg::BYTE_W-1:0] tx_char,
	output logic tx_req,
	input tx_ack
);

	typedef enum logic [1:0] {
		SEQ_IDLE,
		SEQ_ADDR,
		SEQ_LEN,
		SEQ_DATA
	} seq_t;

	typedef enum logic [1:0] {
		HS_FREE,
		HS_REQ,
		HS_DROP
	} hs_t;

	seq_t seq;
	hs_t hs;
	logic sel;
	logic nak_mode, nak_pending;
	logic [ice_pkg::BYTE_W-1:0] nak_addr, raddr, rlen, sent;
	logic [ice_pkg::BYTE_W-1:0] next_byte;
	logic emit;

	//Sequencer may put a byte out only when the link is quiet
	assign emit = (hs == HS_FREE) && (seq != SEQ_IDLE);

	always_comb begin
		case (seq)
			SEQ_ADDR: next_byte = raddr;
			SEQ_LEN: next_byte = rlen;
			default: begin
				if (nak_mode)
					next_byte = ice_pkg::STATUS_NAK;
				else
					next_byte = sel ? sl_data_1 : sl_data_0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			seq <= SEQ_IDLE;
			hs <= HS_FREE;
			tx_req <= 1'b0;
			sl_arb_grant <= '0;
			sl_latch <= 1'b0;
			sel <= 1'b0;
			nak_mode <= 1'b0;
			nak_pending <= 1'b0;
		end else begin
			sl_latch <= 1'b0;
			//Grant follows the request down
			sl_arb_grant <= sl_arb_grant & sl_arb_request;

			//Four-phase host handshake
			case (hs)
				HS_REQ: begin
					if (tx_ack) begin
						tx_req <= 1'b0;
						hs <= HS_DROP;
					end
				end
				HS_DROP: begin
					if (!tx_ack)
						hs <= HS_FREE;
				end
				default: ;
			endcase

			if (emit) begin
				tx_char <= next_byte;
				tx_req <= 1'b1;
				hs <= HS_REQ;
			end

			if (hs == HS_FREE) begin
				case (seq)
					SEQ_IDLE: begin
						//Pending NAK beats any slave
						if (nak_pending) begin
							nak_pending <= 1'b0;
							nak_mode <= 1'b1;
							raddr <= nak_addr;
							rlen <= 8'd1;
							seq <= SEQ_ADDR;
						end else if (sl_arb_grant == '0 && |sl_arb_request) begin
							nak_mode <= 1'b0;
							seq <= SEQ_ADDR;
							//Lowest index wins
							if (sl_arb_request[0]) begin
								sl_arb_grant <= 2'b01;
								sel <= 1'b0;
								raddr <= ice_pkg::ADDR_SETTINGS;
								rlen <= sl_len_0;
							end else begin
								sl_arb_grant <= 2'b10;
								sel <= 1'b1;
								raddr <= ice_pkg::ADDR_ECHO;
								rlen <= sl_len_1;
							end
						end
					end
					SEQ_ADDR: seq <= SEQ_LEN;
					SEQ_LEN: begin
						sent <= '0;
						//Empty reply still needs one latch to release the slave
						if (rlen == '0) begin
							sl_latch <= 1'b1;
							seq <= SEQ_IDLE;
						end else begin
							seq <= SEQ_DATA;
						end
					end
					default: begin
						sl_latch <= !nak_mode;
						sent <= sent + 1'b1;
						if (sent + 1'b1 == rlen)
							seq <= SEQ_IDLE;
					end
				endcase
			end

			//Decoder NAK waits in a one-entry slot
			if (generate_nak) begin
				nak_pending <= 1'b1;
				nak_addr <= ma_addr;
			end
		end
	end

endmodule

// File: logic/ice_bus.sv
module ice_bus (
	input clk,
	input rst,

	//Host character link
	input [ice_pkg::BYTE_W-1:0] rx_char,
	input rx_char_valid,
	output [ice_pkg::BYTE_W-1:0] tx_char,
	output tx_req,
	input tx_ack,

	//Board pads
	output [ice_pkg::BYTE_W-1:0] gpio_level,
	output [ice_pkg::NUM_PWR_SW-1:0] power_sw
);

	//Master bus
	wire [ice_pkg::BYTE_W-1:0] ma_addr, ma_data;
	wire ma_data_valid, ma_frame_valid, ma_frame_end;
	wire generate_nak;

	//Return bus
	wire [ice_pkg::NUM_SLAVES-1:0] sl_arb_request, sl_arb_grant;
	wire sl_latch;
	wire [ice_pkg::BYTE_W-1:0] sl_len_0, sl_data_0;
	wire [ice_pkg::BYTE_W-1:0] sl_len_1, sl_data_1;

	//Host characters into frames
	frame_decoder fd0(
		.clk(clk),
		.rst(rst),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.ma_addr(ma_addr),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.ma_frame_end(ma_frame_end),
		.generate_nak(generate_nak)
	);

	//Slave 0
	settings_regs sr0(
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.ma_frame_end(ma_frame_end),
		.sl_arb_request(sl_arb_request[0]),
		.sl_arb_grant(sl_arb_grant[0]),
		.sl_latch(sl_latch),
		.sl_len(sl_len_0),
		.sl_data(sl_data_0),
		.gpio_level(gpio_level),
		.power_sw(power_sw)
	);

	//Slave 1, loop-back
	echo_port ep0(
		.clk(clk),
		.rst(rst),
		.ma_addr(ma_addr),
		.ma_data(ma_data),
		.ma_data_valid(ma_data_valid),
		.ma_frame_valid(ma_frame_valid),
		.ma_frame_end(ma_frame_end),
		.sl_arb_request(sl_arb_request[1]),
		.sl_arb_grant(sl_arb_grant[1]),
		.sl_latch(sl_latch),
		.sl_len(sl_len_1),
		.sl_data(sl_data_1)
	);

	//Replies back out to the host
	reply_arbiter ra0(
		.clk(clk),
		.rst(rst),
		.sl_arb_request(sl_arb_request),
		.sl_arb_grant(sl_arb_grant),
		.sl_latch(sl_latch),
		.sl_len_0(sl_len_0),
		.sl_data_0(sl_data_0),
		.sl_len_1(sl_len_1),
		.sl_data_1(sl_data_1),
		.generate_nak(generate_nak),
		.ma_addr(ma_addr),
		.tx_char(tx_char),
		.tx_req(tx_req),
		.tx_ack(tx_ack)
	);

endmodule

// File: tb/clock_gen.sv
module clock_gen (
	output logic clk
);

	//Half of the 10 unit period
	localparam int HALF_PERIOD = 5;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: tb/ice_bus_assert.sv
module ice_bus_assert (
	input clk,
	input rst,
	input tx_req,
	input tx_ack,
	input [ice_pkg::NUM_SLAVES-1:0] sl_arb_request,
	input [ice_pkg::NUM_SLAVES-1:0] sl_arb_grant
);

	//Character stays offered until the host answers
	property tx_req_held;
		@(posedge clk) disable iff (rst)
			(tx_req && !tx_ack) |=> tx_req;
	endproperty

	//Single owner of the return bus
	property one_grant;
		@(posedge clk) disable iff (rst)
			$onehot0(sl_arb_grant);
	endproperty

	//Grant may lag a falling request by one cycle only
	property grant_backed(int i);
		@(posedge clk) disable iff (rst)
			sl_arb_grant[i] |-> (sl_arb_request[i] || $past(sl_arb_request[i]));
	endproperty

	a_tx_req_held: assert property (tx_req_held)
		else $error("tx_req dropped before tx_ack rose");
	a_one_grant: assert property (one_grant)
		else $error("more than one slave granted");
	a_grant_0: assert property (grant_backed(0))
		else $error("grant 0 high without a request");
	a_grant_1: assert property (grant_backed(1))
		else $error("grant 1 high without a request");

endmodule

bind ice_bus ice_bus_assert chk (
	.clk(clk),
	.rst(rst),
	.tx_req(tx_req),
	.tx_ack(tx_ack),
	.sl_arb_request(sl_arb_request),
	.sl_arb_grant(sl_arb_grant)
);

// File: tb/tb_ice_bus.sv
module tb_ice_bus;

	typedef logic [7:0] byte_q_t[$];

	//About 45 frames, the 24 slow ones at up to 11 bytes of 46 cycles each
	localparam int WATCHDOG_CYCLES = 20000;
	localparam int SHORT_DELAY = 3;
	localparam int LONG_DELAY = 40;

	logic clk;
	logic rst;
	logic [7:0] rx_char;
	logic rx_char_valid;
	logic [7:0] tx_char;
	logic tx_req;
	logic tx_ack;
	logic [7:0] gpio_level;
	logic [2:0] power_sw;

	integer seed = 32'h3cc8_f8f7;
	int max_delay;
	//Frames since reset, wraps like the DUT counter
	logic [7:0] frames_sent;
	//Register model
	logic [7:0] m_gpio;
	logic [7:0] m_scratch;
	logic [2:0] m_pwr;

	clock_gen clk_src (.clk(clk));

	ice_bus dut (
		.clk(clk),
		.rst(rst),
		.rx_char(rx_char),
		.rx_char_valid(rx_char_valid),
		.tx_char(tx_char),
		.tx_req(tx_req),
		.tx_ack(tx_ack),
		.gpio_level(gpio_level),
		.power_sw(power_sw)
	);

	task automatic fail_run();
		$display("Some tests failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_value(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		assert (got === exp) else begin
			$display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
			fail_run();
		end
	endtask

	//Expected reply frames
	function automatic byte_q_t settings_reply(input logic [7:0] status,
			input logic [7:0] value);
		byte_q_t q;
		q.push_back(ice_pkg::ADDR_SETTINGS);
		q.push_back(8'd2);
		q.push_back(status);
		q.push_back(value);
		return q;
	endfunction

	function automatic byte_q_t nak_reply(input logic [7:0] addr);
		byte_q_t q;
		q.push_back(addr);
		q.push_back(8'd1);
		q.push_back(ice_pkg::STATUS_NAK);
		return q;
	endfunction

	function automatic byte_q_t echo_reply(input byte_q_t pay);
		byte_q_t q;
		q.push_back(ice_pkg::ADDR_ECHO);
		q.push_back(8'(pay.size()));
		foreach (pay[i])
			q.push_back(pay[i]);
		return q;
	endfunction

	//Command payloads
	function automatic byte_q_t read_cmd(input logic [7:0] idx);
		byte_q_t q;
		q.push_back(ice_pkg::OP_READ);
		q.push_back(idx);
		return q;
	endfunction

	function automatic byte_q_t write_cmd(input logic [7:0] idx, input logic [7:0] val);
		byte_q_t q;
		q.push_back(ice_pkg::OP_WRITE);
		q.push_back(idx);
		q.push_back(val);
		return q;
	endfunction

	function automatic byte_q_t random_bytes(input int n);
		byte_q_t q;
		for (int i = 0; i < n; i++)
			q.push_back(8'($random(seed)));
		return q;
	endfunction

	//Host side, one character per cycle
	task automatic send_frame(input logic [7:0] addr, input byte_q_t pay);
		@(posedge clk);
		rx_char <= addr;
		rx_char_valid <= 1'b1;
		@(posedge clk);
		rx_char <= 8'(pay.size());
		foreach (pay[i]) begin
			@(posedge clk);
			rx_char <= pay[i];
		end
		@(posedge clk);
		rx_char_valid <= 1'b0;
		frames_sent = frames_sent + 8'd1;
	endtask

	//One character through the four-phase link, ack after a random wait
	task automatic receive_char(output logic [7:0] c);
		int delay;
		@(posedge clk);
		while (!tx_req)
			@(posedge clk);
		c = tx_char;
		delay = {$random(seed)} % (max_delay + 1);
		repeat (delay) @(posedge clk);
		tx_ack <= 1'b1;
		@(posedge clk);
		while (tx_req)
			@(posedge clk);
		tx_ack <= 1'b0;
	endtask

	task automatic expect_reply(input byte_q_t exp, input string what);
		logic [7:0] c;
		foreach (exp[i]) begin
			receive_char(c);
			check_value($sformatf("tx_char byte %0d of %s", i, what), c, exp[i]);
		end
		//Nothing more once the frame is out
		repeat (4) begin
			@(posedge clk);
			assert (!tx_req) else begin
				$display("Extra byte %h sent after the %s reply", tx_char, what);
				fail_run();
			end
		end
	endtask

	task automatic run_command(input logic [7:0] addr, input byte_q_t pay,
			input byte_q_t exp, input string what);
		send_frame(addr, pay);
		expect_reply(exp, what);
	endtask

	task automatic write_reg(input logic [7:0] idx, input logic [7:0] val);
		run_command(ice_pkg::ADDR_SETTINGS, write_cmd(idx, val),
			settings_reply(ice_pkg::STATUS_ACK, val), "register write");
		if (idx == ice_pkg::REG_GPIO_LEVEL)
			m_gpio = val;
		else if (idx == ice_pkg::REG_POWER_SW)
			m_pwr = val[2:0];
		else
			m_scratch = val;
	endtask

	task automatic read_reg(input logic [7:0] idx, input logic [7:0] exp);
		run_command(ice_pkg::ADDR_SETTINGS, read_cmd(idx),
			settings_reply(ice_pkg::STATUS_ACK, exp), "register read");
	endtask

	task automatic check_pads();
		check_value("gpio_level", gpio_level, m_gpio);
		check_value("power_sw", 8'(power_sw), 8'(m_pwr));
	endtask

	task automatic test_reset_state();
		check_value("tx_req", 8'(tx_req), 8'h00);
		check_pads();
	endtask

	task automatic test_register_write_read();
		write_reg(ice_pkg::REG_GPIO_LEVEL, 8'hA5);
		//Only bits 2..0 reach the switches
		write_reg(ice_pkg::REG_POWER_SW, 8'hFE);
		write_reg(ice_pkg::REG_SCRATCH, 8'h3C);
		read_reg(ice_pkg::REG_GPIO_LEVEL, m_gpio);
		read_reg(ice_pkg::REG_POWER_SW, 8'(m_pwr));
		read_reg(ice_pkg::REG_SCRATCH, m_scratch);
		check_pads();
		write_reg(ice_pkg::REG_GPIO_LEVEL, 8'h5A);
		write_reg(ice_pkg::REG_POWER_SW, 8'h01);
		read_reg(ice_pkg::REG_GPIO_LEVEL, m_gpio);
		read_reg(ice_pkg::REG_POWER_SW, 8'(m_pwr));
		check_pads();
	endtask

	task automatic test_frame_count_and_naks();
		byte_q_t pay;
		byte_q_t nak;
		nak = settings_reply(ice_pkg::STATUS_NAK, 8'h00);
		//Count includes the read frame itself
		read_reg(ice_pkg::REG_FRAME_COUNT, frames_sent + 8'd1);
		run_command(ice_pkg::ADDR_SETTINGS, write_cmd(ice_pkg::REG_FRAME_COUNT, 8'h55),
			nak, "frame count write");
		run_command(ice_pkg::ADDR_SETTINGS, read_cmd(8'd4), nak, "read of index 4");
		run_command(ice_pkg::ADDR_SETTINGS, write_cmd(8'd9, 8'h12), nak, "write of index 9");
		pay = write_cmd(ice_pkg::REG_SCRATCH, 8'h00);
		pay[0] = 8'h07;
		run_command(ice_pkg::ADDR_SETTINGS, pay, nak, "bad opcode");
		//Read with a stray third byte
		pay[0] = ice_pkg::OP_READ;
		run_command(ice_pkg::ADDR_SETTINGS, pay, nak, "long read");
		read_reg(ice_pkg::REG_FRAME_COUNT, frames_sent + 8'd1);
		read_reg(ice_pkg::REG_SCRATCH, m_scratch);
		check_pads();
	endtask

	task automatic test_echo();
		byte_q_t pay;
		pay = random_bytes(0);
		run_command(ice_pkg::ADDR_ECHO, pay, echo_reply(pay), "empty echo");
		pay = random_bytes(1);
		run_command(ice_pkg::ADDR_ECHO, pay, echo_reply(pay), "1-byte echo");
		pay = random_bytes(ice_pkg::ECHO_DEPTH);
		run_command(ice_pkg::ADDR_ECHO, pay, echo_reply(pay), "full echo");
		pay = random_bytes(ice_pkg::ECHO_DEPTH + 1);
		run_command(ice_pkg::ADDR_ECHO, pay, nak_reply(ice_pkg::ADDR_ECHO), "echo overflow");
		//Buffer usable again after overflow
		pay = random_bytes(3);
		run_command(ice_pkg::ADDR_ECHO, pay, echo_reply(pay), "echo after overflow");
	endtask

	task automatic test_unknown_address();
		run_command(8'h7E, random_bytes(2), nak_reply(8'h7E), "unknown address");
		run_command(8'h00, random_bytes(0), nak_reply(8'h00), "empty unknown frame");
	endtask

	task automatic test_slow_host();
		byte_q_t pay;
		logic [7:0] val;
		logic [7:0] addr;
		max_delay = LONG_DELAY;
		repeat (6) begin
			pay = random_bytes({$random(seed)} % ice_pkg::ECHO_DEPTH + 1);
			run_command(ice_pkg::ADDR_ECHO, pay, echo_reply(pay), "slow echo");
			val = 8'($random(seed));
			write_reg(ice_pkg::REG_SCRATCH, val);
			read_reg(ice_pkg::REG_SCRATCH, m_scratch);
			//Addresses 0x10 and up hit no slave
			addr = 8'h10 + 8'({$random(seed)} % 200);
			run_command(addr, random_bytes(1), nak_reply(addr), "slow unknown address");
		end
		max_delay = SHORT_DELAY;
	endtask

	initial begin
		rst = 1'b1;
		rx_char = '0;
		rx_char_valid = 1'b0;
		tx_ack = 1'b0;
		max_delay = SHORT_DELAY;
		frames_sent = '0;
		m_gpio = '0;
		m_scratch = '0;
		m_pwr = '0;
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_reset_state();
		test_register_write_read();
		test_frame_count_and_naks();
		test_echo();
		test_unknown_address();
		test_slow_host();
		$display("All tests passed");
		$finish;
	end

	//Watchdog
	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYCLES);
		fail_run();
	end

endmodule

// File: ice_bus.f
logic/ice_pkg.sv
logic/frame_decoder.sv
logic/settings_regs.sv
logic/echo_port.sv
logic/reply_arbiter.sv
logic/ice_bus.sv
tb/clock_gen.sv
tb/ice_bus_assert.sv
tb/tb_ice_bus.sv

// File: Makefile
SIM := obj_dir/Vtb_ice_bus
SRCS := $(wildcard logic/*.sv tb/*.sv)

.PHONY: run clean

run: $(SIM)
	$(SIM) | tee sim.log
	grep -q "All tests passed" sim.log

$(SIM): $(SRCS) ice_bus.f
	verilator --binary --timing --assert --top-module tb_ice_bus -Mdir obj_dir -f ice_bus.f

clean:
	rm -rf obj_dir sim.log
